//--- list.f
+incdir+test
common/decode_pkg.sv
hdl/instr_rx.sv
decoder/control_decoder.sv
decoder/extend_imm.sv
hdl/decode_tx.sv
hdl/decode_top.sv
test/decode_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps
TOP       = decode_tb
FILELIST  = list.f
BIN       = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir

//--- test/decode_model.svh
// Decode reference model: expected fields of one instruction word from the RISC-V rules.

`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Immediate kind chosen by the opcode alone.
function automatic imm_sel_t imm_kind_of(input logic [31:0] w);
    case (w[6:0])
        OPC_LUI, OPC_AUIPC: return IMM_U;
        OPC_JAL:            return IMM_J;
        OPC_BRANCH:         return IMM_B;
        OPC_STORE:          return IMM_S;
        // Illegal words fall back to I as well.
        default:            return IMM_I;
    endcase
endfunction

// Immediate rebuilt straight from instruction bit positions.
function automatic logic [XLEN-1:0] sign_ext_imm(input logic [31:0] w);
    logic [31:0] low;
    case (imm_kind_of(w))
        IMM_U:   low = {w[31:12], 12'h000};
        IMM_J:   low = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        IMM_B:   low = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        IMM_S:   low = {{21{w[31]}}, w[30:25], w[11:7]};
        default: low = {{21{w[31]}}, w[30:20]};
    endcase
    // Bit 31 fills the rest of the data word.
    return {{(XLEN-32){low[31]}}, low};
endfunction

// ALU operation from opcode, funct3 and bit 30.
function automatic alu_op_t alu_op_of(input logic [31:0] w);
    logic [6:0] opc;
    logic       reg_form;
    alu_op_t    op;
    opc      = w[6:0];
    reg_form = (opc == OPC_OP) || (opc == OPC_OP32);
    op       = ADD;
    if (opc == OPC_LUI) begin
        op = PASS_B;
    end
    else if (opc inside {OPC_OP, OPC_OP32, OPC_OPIMM, OPC_OPIMM32}) begin
        case (w[14:12])
            3'd0:    op = (reg_form && w[30]) ? SUB : ADD;
            3'd1:    op = SLL;
            3'd2:    op = SLT;
            3'd3:    op = SLTU;
            3'd4:    op = XOR;
            3'd5:    op = w[30] ? SRA : SRL;
            3'd6:    op = OR;
            default: op = AND;
        endcase
    end
    return op;
endfunction

// Flags, msb first: use_imm, reg_write, mem_read, mem_write, branch, jump, word_op, illegal.
function automatic logic [7:0] flag_set_of(input logic [31:0] w);
    case (w[6:0])
        OPC_LUI, OPC_AUIPC: return 8'b1100_0000;
        OPC_JAL, OPC_JALR:  return 8'b1100_0100;
        OPC_LOAD:           return 8'b1110_0000;
        OPC_STORE:          return 8'b1001_0000;
        OPC_BRANCH:         return 8'b1000_1000;
        OPC_OPIMM:          return 8'b1100_0000;
        OPC_OPIMM32:        return 8'b1100_0010;
        OPC_OP:             return 8'b0100_0000;
        OPC_OP32:           return 8'b0100_0010;
        default:            return 8'b0000_0001;
    endcase
endfunction

// Register fields as {rd, rs1, rs2}; unused ones read zero.
function automatic logic [14:0] reg_fields_of(input logic [31:0] w);
    logic [6:0] opc;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    opc = w[6:0];
    rd  = 5'd0;
    rs1 = 5'd0;
    rs2 = 5'd0;
    if (opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_LOAD,
                    OPC_OPIMM, OPC_OPIMM32, OPC_OP, OPC_OP32}) begin
        rd = w[11:7];
    end
    if (opc inside {OPC_JALR, OPC_LOAD, OPC_BRANCH, OPC_STORE,
                    OPC_OPIMM, OPC_OPIMM32, OPC_OP, OPC_OP32}) begin
        rs1 = w[19:15];
    end
    if (opc inside {OPC_OP, OPC_OP32, OPC_STORE, OPC_BRANCH}) begin
        rs2 = w[24:20];
    end
    return {rd, rs1, rs2};
endfunction

`endif

//--- test/decode_tb.sv
// Decode stage testbench that checks random fetch and execute handshakes against a model.

`timescale 1ns/1ps
`default_nettype none

module decode_tb;

    import decode_pkg::*;

    localparam int XLEN          = 64;
    localparam int N_INSTR       = 500;
    localparam int CLK_PERIOD    = 4;
    localparam int CYC_PER_INSTR = 20;

    `include "decode_model.svh"

    // DUT connections.
    logic            clk;
    logic            rst;
    logic            in_req;
    logic [31:0]     in_instr;
    logic            in_ack;
    logic            out_req;
    logic            out_ack;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    alu_op_t         alu_op;
    imm_sel_t        imm_sel;
    logic            use_imm;
    logic            reg_write;
    logic            mem_read;
    logic            mem_write;
    logic            branch;
    logic            jump;
    logic            word_op;
    logic            illegal;
    logic [XLEN-1:0] imm;

    // Scoreboard state.
    integer          seed;
    int              n_out;
    logic [31:0]     sent_q [$];

    decode_top #(
        .XLEN (XLEN)
    ) dut (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_in_req    (in_req),
        .i_in_instr  (in_instr),
        .o_in_ack    (in_ack),
        .o_out_req   (out_req),
        .i_out_ack   (out_ack),
        .o_rd        (rd),
        .o_rs1       (rs1),
        .o_rs2       (rs2),
        .o_alu_op    (alu_op),
        .o_imm_sel   (imm_sel),
        .o_use_imm   (use_imm),
        .o_reg_write (reg_write),
        .o_mem_read  (mem_read),
        .o_mem_write (mem_write),
        .o_branch    (branch),
        .o_jump      (jump),
        .o_word_op   (word_op),
        .o_illegal   (illegal),
        .o_imm       (imm)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------------------------------------
    // Failure paths and compare tasks.
    // ----------------------------------------------------------------------
    task automatic stop_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic value_error(input string msg);
        $display("** Error [%0t] %s", $time, msg);
        stop_run();
    endtask

    task automatic check_imm(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                             input int idx);
        if (got !== exp) begin
            value_error($sformatf("item %0d imm got %h expected %h", idx, got, exp));
        end
    endtask

    task automatic check_alu(input alu_op_t got, input alu_op_t exp, input int idx);
        if (got !== exp) begin
            value_error($sformatf("item %0d alu op got %s expected %s",
                                  idx, got.name(), exp.name()));
        end
    endtask

    task automatic check_sel_flags(input imm_sel_t got_sel, input imm_sel_t exp_sel,
                                   input logic [7:0] got_flags, input logic [7:0] exp_flags,
                                   input int idx);
        if (got_sel !== exp_sel || got_flags !== exp_flags) begin
            value_error($sformatf("item %0d sel/flags got %s/%b expected %s/%b", idx,
                                  got_sel.name(), got_flags, exp_sel.name(), exp_flags));
        end
    endtask

    task automatic check_regs(input logic [14:0] got, input logic [14:0] exp, input int idx);
        if (got !== exp) begin
            value_error($sformatf("item %0d rd/rs1/rs2 got %h expected %h", idx, got, exp));
        end
    endtask

    // Both links idle out of reset.
    task automatic check_idle();
        if (in_ack !== 1'b0 || out_req !== 1'b0) begin
            value_error($sformatf("after reset ack %b req %b, both expected 0",
                                  in_ack, out_req));
        end
    endtask

    // ----------------------------------------------------------------------
    // Producer and consumer.
    // ----------------------------------------------------------------------
    function automatic logic [6:0] opcode_at(input int idx);
        case (idx)
            0:       return OPC_LUI;
            1:       return OPC_AUIPC;
            2:       return OPC_JAL;
            3:       return OPC_JALR;
            4:       return OPC_BRANCH;
            5:       return OPC_LOAD;
            6:       return OPC_STORE;
            7:       return OPC_OPIMM;
            8:       return OPC_OP;
            9:       return OPC_OPIMM32;
            default: return OPC_OP32;
        endcase
    endfunction

    // Four-phase source on the fetch side.
    task automatic produce();
        instr_u word;
        int     gap;
        for (int k = 0; k < N_INSTR; k++) begin
            word = $random(seed);
            // Most words get a base opcode, the rest stay raw.
            if (($unsigned($random(seed)) % 10) < 7) begin
                word.r.opcode = opcode_at($unsigned($random(seed)) % 11);
            end
            in_req   <= 1'b1;
            in_instr <= word;
            @(posedge clk);
            while (!in_ack) @(posedge clk);
            sent_q.push_back(word);
            in_req <= 1'b0;
            @(posedge clk);
            while (in_ack) @(posedge clk);
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(posedge clk);
        end
    endtask

    // Four-phase sink on the execute side with a random stall.
    task automatic consume();
        logic [31:0] w;
        int          delay;
        for (int k = 0; k < N_INSTR; k++) begin
            @(posedge clk);
            while (!out_req) @(posedge clk);
            delay = $unsigned($random(seed)) % 6;
            repeat (delay) begin
                @(posedge clk);
                if (!out_req) begin
                    $display("Output request dropped before ack on item %0d", k);
                    stop_run();
                end
            end
            if (sent_q.size() == 0) begin
                $display("Output item %0d appeared with no word sent", k);
                stop_run();
            end
            w = sent_q.pop_front();
            check_imm(imm, sign_ext_imm(w), k);
            check_alu(alu_op, alu_op_of(w), k);
            check_sel_flags(imm_sel, imm_kind_of(w),
                            {use_imm, reg_write, mem_read, mem_write,
                             branch, jump, word_op, illegal},
                            flag_set_of(w), k);
            check_regs({rd, rs1, rs2}, reg_fields_of(w), k);
            out_ack <= 1'b1;
            @(posedge clk);
            while (out_req) @(posedge clk);
            out_ack <= 1'b0;
            n_out++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence and watchdog.
    // ----------------------------------------------------------------------
    initial begin
        seed     = 32'h83f1_b6e4;
        n_out    = 0;
        clk      = 1'b0;
        rst      = 1'b1;
        in_req   = 1'b0;
        in_instr = 32'd0;
        out_ack  = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_idle();
        fork
            produce();
            consume();
        join
        // A stray extra result would raise req again in this window.
        repeat (CYC_PER_INSTR) @(posedge clk);
        if (out_req === 1'b0 && in_ack === 1'b0) begin
            $display("Regression passed");
            $finish;
        end
        else begin
            $display("Activity after the last result, output req %b input ack %b",
                     out_req, in_ack);
            stop_run();
        end
    end

    initial begin
        #(N_INSTR * CYC_PER_INSTR * CLK_PERIOD);
        $display("Timeout: only %0d of %0d results handed off", n_out, N_INSTR);
        stop_run();
    end

endmodule

`default_nettype wire

//--- hdl/decode_top.sv
// Decode stage top: receiver, control decoder, immediate extender and transmitter.

`timescale 1ns/1ps
`default_nettype none

module decode_top #(
    parameter int XLEN = 64
) (
    // Clock and reset.
    input  logic                  i_clk,
    input  logic                  i_rst,

    // Fetch link.
    input  logic                  i_in_req,
    input  logic [31:0]           i_in_instr,
    output logic                  o_in_ack,

    // Execute link.
    output logic                  o_out_req,
    input  logic                  i_out_ack,
    output logic [4:0]            o_rd,
    output logic [4:0]            o_rs1,
    output logic [4:0]            o_rs2,
    output decode_pkg::alu_op_t   o_alu_op,
    output decode_pkg::imm_sel_t  o_imm_sel,
    output logic                  o_use_imm,
    output logic                  o_reg_write,
    output logic                  o_mem_read,
    output logic                  o_mem_write,
    output logic                  o_branch,
    output logic                  o_jump,
    output logic                  o_word_op,
    output logic                  o_illegal,
    output logic [XLEN-1:0]       o_imm
);

    import decode_pkg::*;

    // Buffered word.
    instr_u          rx_instr;
    logic            rx_valid;
    logic            take;

    // Combinational decode results.
    logic [4:0]      dec_rd;
    logic [4:0]      dec_rs1;
    logic [4:0]      dec_rs2;
    alu_op_t         dec_alu_op;
    imm_sel_t        dec_imm_sel;
    logic            dec_use_imm;
    logic            dec_reg_write;
    logic            dec_mem_read;
    logic            dec_mem_write;
    logic            dec_branch;
    logic            dec_jump;
    logic            dec_word_op;
    logic            dec_illegal;
    logic [XLEN-1:0] dec_imm;

    // ----------------------------------------------------------------------
    // Input side.
    // ----------------------------------------------------------------------
    instr_rx u_rx (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_in_req   (i_in_req),
        .i_in_instr (i_in_instr),
        .o_in_ack   (o_in_ack),
        .i_take     (take),
        .o_valid    (rx_valid),
        .o_instr    (rx_instr)
    );

    // Decode path, no clock.
    control_decoder u_dec (
        .i_instr     (rx_instr),
        .o_rd        (dec_rd),
        .o_rs1       (dec_rs1),
        .o_rs2       (dec_rs2),
        .o_alu_op    (dec_alu_op),
        .o_imm_sel   (dec_imm_sel),
        .o_use_imm   (dec_use_imm),
        .o_reg_write (dec_reg_write),
        .o_mem_read  (dec_mem_read),
        .o_mem_write (dec_mem_write),
        .o_branch    (dec_branch),
        .o_jump      (dec_jump),
        .o_word_op   (dec_word_op),
        .o_illegal   (dec_illegal)
    );

    extend_imm #(
        .XLEN (XLEN)
    ) u_ext (
        .i_instr   (rx_instr),
        .i_imm_sel (dec_imm_sel),
        .o_imm_ext (dec_imm)
    );

    // ----------------------------------------------------------------------
    // Output side.
    // ----------------------------------------------------------------------
    decode_tx #(
        .XLEN (XLEN)
    ) u_tx (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_valid     (rx_valid),
        .i_rd        (dec_rd),
        .i_rs1       (dec_rs1),
        .i_rs2       (dec_rs2),
        .i_alu_op    (dec_alu_op),
        .i_imm_sel   (dec_imm_sel),
        .i_use_imm   (dec_use_imm),
        .i_reg_write (dec_reg_write),
        .i_mem_read  (dec_mem_read),
        .i_mem_write (dec_mem_write),
        .i_branch    (dec_branch),
        .i_jump      (dec_jump),
        .i_word_op   (dec_word_op),
        .i_illegal   (dec_illegal),
        .i_imm       (dec_imm),
        .o_take      (take),
        .o_out_req   (o_out_req),
        .i_out_ack   (i_out_ack),
        .o_rd        (o_rd),
        .o_rs1       (o_rs1),
        .o_rs2       (o_rs2),
        .o_alu_op    (o_alu_op),
        .o_imm_sel   (o_imm_sel),
        .o_use_imm   (o_use_imm),
        .o_reg_write (o_reg_write),
        .o_mem_read  (o_mem_read),
        .o_mem_write (o_mem_write),
        .o_branch    (o_branch),
        .o_jump      (o_jump),
        .o_word_op   (o_word_op),
        .o_illegal   (o_illegal),
        .o_imm       (o_imm)
    );

endmodule

`default_nettype wire

//--- hdl/decode_tx.sv
// Decode transmitter: registers the decoded bundle and offers it as a four-phase source.

`timescale 1ns/1ps
`default_nettype none

module decode_tx #(
    parameter int XLEN = 64
) (
    // Clock and reset.
    input  logic                  i_clk,
    input  logic                  i_rst,

    // Decoded bundle in.
    input  logic                  i_valid,
    input  logic [4:0]            i_rd,
    input  logic [4:0]            i_rs1,
    input  logic [4:0]            i_rs2,
    input  decode_pkg::alu_op_t   i_alu_op,
    input  decode_pkg::imm_sel_t  i_imm_sel,
    input  logic                  i_use_imm,
    input  logic                  i_reg_write,
    input  logic                  i_mem_read,
    input  logic                  i_mem_write,
    input  logic                  i_branch,
    input  logic                  i_jump,
    input  logic                  i_word_op,
    input  logic                  i_illegal,
    input  logic [XLEN-1:0]       i_imm,
    output logic                  o_take,

    // Execute side handshake.
    output logic                  o_out_req,
    input  logic                  i_out_ack,
    output logic [4:0]            o_rd,
    output logic [4:0]            o_rs1,
    output logic [4:0]            o_rs2,
    output decode_pkg::alu_op_t   o_alu_op,
    output decode_pkg::imm_sel_t  o_imm_sel,
    output logic                  o_use_imm,
    output logic                  o_reg_write,
    output logic                  o_mem_read,
    output logic                  o_mem_write,
    output logic                  o_branch,
    output logic                  o_jump,
    output logic                  o_word_op,
    output logic                  o_illegal,
    output logic [XLEN-1:0]       o_imm
);

    import decode_pkg::*;

    logic slot_full;

    // Load edge; the same pulse frees the input buffer.
    assign o_take = i_valid && !slot_full;

    // ----------------------------------------------------------------------
    // Source half of the handshake.
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            slot_full <= 1'b0;
            o_out_req <= 1'b0;
        end
        else if (o_take) begin
            slot_full <= 1'b1;
            o_out_req <= 1'b1;
        end
        else if (o_out_req && i_out_ack) begin
            o_out_req <= 1'b0;
        end
        else if (slot_full && !o_out_req && !i_out_ack) begin
            // Return to zero done.
            slot_full <= 1'b0;
        end
    end

    // Bundle register.
    always_ff @(posedge i_clk) begin
        if (o_take) begin
            o_rd        <= i_rd;
            o_rs1       <= i_rs1;
            o_rs2       <= i_rs2;
            o_alu_op    <= i_alu_op;
            o_imm_sel   <= i_imm_sel;
            o_use_imm   <= i_use_imm;
            o_reg_write <= i_reg_write;
            o_mem_read  <= i_mem_read;
            o_mem_write <= i_mem_write;
            o_branch    <= i_branch;
            o_jump      <= i_jump;
            o_word_op   <= i_word_op;
            o_illegal   <= i_illegal;
            o_imm       <= i_imm;
        end
    end

    // Req and payload hold until the sink answers.
    a_req_hold : assert property (
        @(posedge i_clk) disable iff (i_rst)
        (o_out_req && !i_out_ack) |=>
            (o_out_req && $stable(o_imm) && $stable(o_alu_op) && $stable(o_rd))
    );

endmodule

`default_nettype wire

//--- decoder/extend_imm.sv
// Immediate extender: rebuilds the I, S, B, J or U immediate and sign-extends it.

`timescale 1ns/1ps
`default_nettype none

module extend_imm #(
    parameter int XLEN = 64
) (
    // Instruction word and kind of immediate.
    input  decode_pkg::instr_u    i_instr,
    input  decode_pkg::imm_sel_t  i_imm_sel,

    // Extended immediate.
    output logic [XLEN-1:0]       o_imm_ext
);

    import decode_pkg::*;

    logic        sign;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] imm_u;
    logic [31:0] imm_sel32;

    // Sign always sits in instruction bit 31.
    assign sign = i_instr.r.funct7[6];

    // ----------------------------------------------------------------------
    // Per-format rebuild, first to 32 bits.
    // ----------------------------------------------------------------------
    assign imm_i = {{20{sign}}, i_instr.i.imm};
    assign imm_s = {{20{sign}}, i_instr.s.imm_hi, i_instr.s.imm_lo};
    assign imm_b = {{19{sign}}, i_instr.b.imm_12, i_instr.b.imm_11,
                    i_instr.b.imm_10_5, i_instr.b.imm_4_1, 1'b0};
    assign imm_j = {{11{sign}}, i_instr.j.imm_20, i_instr.j.imm_19_12,
                    i_instr.j.imm_11, i_instr.j.imm_10_1, 1'b0};
    // Upper 20 bits, twelve zeros below.
    assign imm_u = {i_instr.u.imm, 12'd0};

    // Mux on the select bits; bit 2 alone means U.
    always_comb begin
        if (i_imm_sel[2]) begin
            imm_sel32 = imm_u;
        end
        else if (i_imm_sel[1]) begin
            imm_sel32 = i_imm_sel[0] ? imm_j : imm_b;
        end
        else begin
            imm_sel32 = i_imm_sel[0] ? imm_s : imm_i;
        end

        // The decoder never names a code past U.
        a_sel_range : assert (i_imm_sel <= IMM_U);
    end

    // Signed cast widens the word to XLEN.
    assign o_imm_ext = XLEN'($signed(imm_sel32));

endmodule

`default_nettype wire

//--- decoder/control_decoder.sv
// Control decoder: opcode, funct3 and funct7 to flags, ALU op and register fields.

`timescale 1ns/1ps
`default_nettype none

module control_decoder (
    // Instruction word.
    input  decode_pkg::instr_u    i_instr,

    // Register addresses, zero when unused.
    output logic [4:0]            o_rd,
    output logic [4:0]            o_rs1,
    output logic [4:0]            o_rs2,

    // Operation and control flags.
    output decode_pkg::alu_op_t   o_alu_op,
    output decode_pkg::imm_sel_t  o_imm_sel,
    output logic                  o_use_imm,
    output logic                  o_reg_write,
    output logic                  o_mem_read,
    output logic                  o_mem_write,
    output logic                  o_branch,
    output logic                  o_jump,
    output logic                  o_word_op,
    output logic                  o_illegal
);

    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       f7_b5;

    // Fields share positions in every format.
    assign opcode = i_instr.r.opcode;
    assign funct3 = i_instr.r.funct3;
    // Instruction bit 30.
    assign f7_b5  = i_instr.r.funct7[5];

    // funct3 map; SUB only exists for register-register ops.
    // SRA is picked by bit 30 in both forms.
    function automatic alu_op_t alu_from_funct(input logic [2:0] f3,
                                               input logic       b30,
                                               input logic       reg_op);
        alu_op_t op;
        case (f3)
            3'b000: begin
                if (reg_op && b30) op = SUB;
                else               op = ADD;
            end
            3'b001: op = SLL;
            3'b010: op = SLT;
            3'b011: op = SLTU;
            3'b100: op = XOR;
            3'b101: begin
                if (b30) op = SRA;
                else     op = SRL;
            end
            3'b110: op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    // ----------------------------------------------------------------------
    // Main decode.
    // ----------------------------------------------------------------------
    always_comb begin
        // Defaults match the illegal case, bar the flag itself.
        o_rd        = 5'd0;
        o_rs1       = 5'd0;
        o_rs2       = 5'd0;
        o_alu_op    = ADD;
        o_imm_sel   = IMM_I;
        o_use_imm   = 1'b0;
        o_reg_write = 1'b0;
        o_mem_read  = 1'b0;
        o_mem_write = 1'b0;
        o_branch    = 1'b0;
        o_jump      = 1'b0;
        o_word_op   = 1'b0;
        o_illegal   = 1'b0;

        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                o_rd        = i_instr.u.rd;
                o_reg_write = 1'b1;
                o_use_imm   = 1'b1;
                o_imm_sel   = IMM_U;
                // LUI passes the immediate, AUIPC adds it to pc.
                if (opcode == OPC_LUI) o_alu_op = PASS_B;
            end
            OPC_JAL: begin
                o_rd        = i_instr.j.rd;
                o_reg_write = 1'b1;
                o_jump      = 1'b1;
                o_use_imm   = 1'b1;
                o_imm_sel   = IMM_J;
            end
            OPC_JALR, OPC_LOAD: begin
                o_rd        = i_instr.i.rd;
                o_rs1       = i_instr.i.rs1;
                o_reg_write = 1'b1;
                o_use_imm   = 1'b1;
                o_jump      = (opcode == OPC_JALR);
                o_mem_read  = (opcode == OPC_LOAD);
            end
            OPC_BRANCH: begin
                // ALU forms the target, rs1 and rs2 go to the comparator.
                o_rs1     = i_instr.b.rs1;
                o_rs2     = i_instr.b.rs2;
                o_branch  = 1'b1;
                o_use_imm = 1'b1;
                o_imm_sel = IMM_B;
            end
            OPC_STORE: begin
                o_rs1       = i_instr.s.rs1;
                o_rs2       = i_instr.s.rs2;
                o_mem_write = 1'b1;
                o_use_imm   = 1'b1;
                o_imm_sel   = IMM_S;
            end
            OPC_OPIMM, OPC_OPIMM32: begin
                o_rd        = i_instr.i.rd;
                o_rs1       = i_instr.i.rs1;
                o_reg_write = 1'b1;
                o_use_imm   = 1'b1;
                o_word_op   = (opcode == OPC_OPIMM32);
                o_alu_op    = alu_from_funct(funct3, f7_b5, 1'b0);
            end
            OPC_OP, OPC_OP32: begin
                o_rd        = i_instr.r.rd;
                o_rs1       = i_instr.r.rs1;
                o_rs2       = i_instr.r.rs2;
                o_reg_write = 1'b1;
                o_word_op   = (opcode == OPC_OP32);
                o_alu_op    = alu_from_funct(funct3, f7_b5, 1'b1);
            end
            default: begin
                o_illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/instr_rx.sv
// Instruction receiver: four-phase sink from fetch with a one-word buffer.

`timescale 1ns/1ps
`default_nettype none

module instr_rx (
    // Clock and reset.
    input  logic                  i_clk,
    input  logic                  i_rst,

    // Fetch side handshake.
    input  logic                  i_in_req,
    input  logic [31:0]           i_in_instr,
    output logic                  o_in_ack,

    // Toward the decoder.
    input  logic                  i_take,
    output logic                  o_valid,
    output decode_pkg::instr_u    o_instr
);

    import decode_pkg::*;

    logic buf_load;

    // Accept only with an empty buffer and ack already low.
    // A full buffer holds ack low, which stalls fetch.
    assign buf_load = i_in_req && !o_valid && !o_in_ack;

    // ----------------------------------------------------------------------
    // Handshake and valid flag.
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_in_ack <= 1'b0;
            o_valid  <= 1'b0;
        end
        else begin
            // Ack rises after capture, falls once req is seen low.
            if (buf_load) begin
                o_in_ack <= 1'b1;
            end
            else if (!i_in_req) begin
                o_in_ack <= 1'b0;
            end

            // Load and take never meet, take needs a full buffer.
            if (buf_load) begin
                o_valid <= 1'b1;
            end
            else if (i_take) begin
                o_valid <= 1'b0;
            end
        end
    end

    // Word buffer.
    always_ff @(posedge i_clk) begin
        if (buf_load) begin
            o_instr <= i_in_instr;
        end
    end

    // Ack only answers a request.
    a_ack_follows_req : assert property (
        @(posedge i_clk) disable iff (i_rst)
        $rose(o_in_ack) |-> $past(i_in_req)
    );

    // A held word is not overwritten before the transmitter takes it.
    a_buf_held : assert property (
        @(posedge i_clk) disable iff (i_rst)
        (o_valid && !i_take) |=> (o_valid && $stable(o_instr))
    );

endmodule

`default_nettype wire

//--- common/decode_pkg.sv
// RV64I decode package: instruction formats, immediate and ALU encodings, opcodes.

`default_nettype none

package decode_pkg;

    // ----------------------------------------------------------------------
    // Instruction formats, most significant field first.
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // Branch offset is scrambled across the word.
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // Jump offset, also scrambled.
    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One 32-bit word, six views of it.
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    // ----------------------------------------------------------------------
    // Encodings.
    // ----------------------------------------------------------------------
    // Immediate kinds, same codes as the extender mux table.
    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_J = 3'd3,
        IMM_U = 3'd4
    } imm_sel_t;

    // ALU operations; PASS_B forwards operand B (LUI).
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10
    } alu_op_t;

    // Base integer and memory opcodes.
    localparam logic [6:0] OPC_LUI     = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
    localparam logic [6:0] OPC_JAL     = 7'b1101111;
    localparam logic [6:0] OPC_JALR    = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;
    localparam logic [6:0] OPC_STORE   = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP      = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM32 = 7'b0011011;
    localparam logic [6:0] OPC_OP32    = 7'b0111011;

endpackage

`default_nettype wire
